/* include/coh_consts.svh */
/*
 * coherence message unit constants
 * widths, counts and the id of this directory controller
 */
`ifndef COH_CONSTS_SVH
`define COH_CONSTS_SVH

// physical address and payload widths
`define PADDR_WIDTH     20
`define BLOCK_WIDTH     128
`define DWORD_WIDTH     64

// local cache engines, id width follows the count
`define NUM_LCE         8
`define LG_NUM_LCE      3

// associativity of each LCE
`define LCE_ASSOC       4
`define LG_ASSOC        2

// block offset and set index, the set index is also the way group
`define LG_BLOCK_BYTES  4
`define LG_SETS         6

// outstanding invalidate ack counter, holds up to NUM_LCE
`define INV_CNT_WIDTH   4

// id placed in the source field of every command we send
`define CCE_ID          3'd1

`endif

/* design/coh_pkg.sv */
/*
 * coherence message unit types
 * message encodings, FSM state and packed message layouts
 */
`include "coh_consts.svh"

package coh_pkg;

  // memory response type
  typedef enum logic [2:0] {
    e_mem_rd    = 3'b000,
    e_mem_wr    = 3'b001,
    e_mem_uc_rd = 3'b010,
    e_mem_uc_wr = 3'b011,
    e_mem_wb    = 3'b100
  } mem_msg_type_e;

  // commands this unit can send to an LCE
  typedef enum logic [1:0] {
    e_cmd_data       = 2'b00,
    e_cmd_uc_data    = 2'b01,
    e_cmd_uc_st_done = 2'b10,
    e_cmd_inv        = 2'b11
  } lce_cmd_type_e;

  typedef enum logic {
    e_resp_coh_ack = 1'b0,
    e_resp_inv_ack = 1'b1
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_req_rd    = 2'b00,
    e_req_wr    = 2'b01,
    e_req_uc_rd = 2'b10,
    e_req_uc_wr = 2'b11
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01,
    e_coh_e = 2'b10,
    e_coh_m = 2'b11
  } coh_state_e;

  // invalidation sequencer
  typedef enum logic [1:0] {
    e_inv_ready = 2'b00,
    e_inv_cmd   = 2'b01,
    e_inv_resp  = 2'b10
  } inv_state_e;

  typedef struct packed {
    mem_msg_type_e                msg_type;
    logic [`PADDR_WIDTH-1:0]      addr;
    logic [`BLOCK_WIDTH-1:0]      data;
    logic [`LG_NUM_LCE-1:0]       lce_id;
    logic [`LG_ASSOC-1:0]         way_id;
    coh_state_e                   state;
  } mem_resp_t;

  typedef struct packed {
    lce_cmd_type_e                msg_type;
    logic [`LG_NUM_LCE-1:0]       dst_id;
    logic [`LG_NUM_LCE-1:0]       src_id;
    logic [`LG_ASSOC-1:0]         way_id;
    logic [`PADDR_WIDTH-1:0]      addr;
    coh_state_e                   state;
    logic [`BLOCK_WIDTH-1:0]      data;
  } lce_cmd_t;

  typedef struct packed {
    lce_resp_type_e               msg_type;
    logic [`LG_NUM_LCE-1:0]       src_id;
    logic [`PADDR_WIDTH-1:0]      addr;
  } lce_resp_t;

  typedef struct packed {
    lce_req_type_e                msg_type;
    logic [`LG_NUM_LCE-1:0]       src_id;
    logic [`PADDR_WIDTH-1:0]      addr;
  } lce_req_t;

  // one write to the pending bit store
  typedef struct packed {
    logic                         w_v;
    logic [`LG_SETS-1:0]          way_group;
    logic                         pending;
  } pend_wr_t;

  // directory lookup result handed to the sequencer
  typedef struct packed {
    logic [`PADDR_WIDTH-1:0]                  addr;
    logic [`LG_NUM_LCE-1:0]                   req_lce;
    logic [`NUM_LCE-1:0]                      sharer_hits;
    logic [`NUM_LCE-1:0][`LG_ASSOC-1:0]       sharer_ways;
  } inv_start_t;

endpackage

/* design/mem_resp_forward.sv */
/*
 * memory response forwarder
 * turns each memory response into an LCE command or a pending clear
 */
`include "coh_consts.svh"

module mem_resp_forward
  import coh_pkg::*;
(
  input  mem_resp_t mem_resp_i,
  input  logic      mem_resp_v_i,
  output logic      fwd_cmd_v_o,
  output lce_cmd_t  fwd_cmd_o,
  output logic      fwd_clr_v_o,
  output logic      fwd_needs_cmd_o
);

  always_comb begin
    // common command fields
    fwd_cmd_o          = '0;
    fwd_cmd_o.dst_id   = mem_resp_i.lce_id;
    fwd_cmd_o.src_id   = `CCE_ID;
    fwd_cmd_o.addr     = mem_resp_i.addr;
    fwd_cmd_o.state    = e_coh_i;
    fwd_cmd_o.msg_type = e_cmd_data;

    fwd_cmd_v_o     = 1'b0;
    fwd_clr_v_o     = 1'b0;
    fwd_needs_cmd_o = 1'b0;

    case (mem_resp_i.msg_type)
      // cached fill, full block to the requester
      e_mem_rd, e_mem_wr: begin
        fwd_cmd_o.msg_type = e_cmd_data;
        fwd_cmd_o.way_id   = mem_resp_i.way_id;
        fwd_cmd_o.state    = mem_resp_i.state;
        fwd_cmd_o.data     = mem_resp_i.data;
        fwd_cmd_v_o        = mem_resp_v_i;
        // clear is only written once the command fires
        fwd_clr_v_o        = mem_resp_v_i;
        fwd_needs_cmd_o    = 1'b1;
      end

      // uncached load, only the low dword carries data
      e_mem_uc_rd: begin
        fwd_cmd_o.msg_type                  = e_cmd_uc_data;
        fwd_cmd_o.way_id                    = '0;
        fwd_cmd_o.data[`DWORD_WIDTH-1:0]    = mem_resp_i.data[`DWORD_WIDTH-1:0];
        fwd_cmd_v_o                         = mem_resp_v_i;
        fwd_needs_cmd_o                     = 1'b1;
      end

      // uncached store finished in memory
      e_mem_uc_wr: begin
        fwd_cmd_o.msg_type = e_cmd_uc_st_done;
        fwd_cmd_o.way_id   = '0;
        fwd_cmd_v_o        = mem_resp_v_i;
        fwd_needs_cmd_o    = 1'b1;
      end

      // writeback ack, nothing to send, just close the transaction
      e_mem_wb: begin
        fwd_clr_v_o = mem_resp_v_i;
      end

      // unknown type, drained without side effects
      default: begin
        fwd_cmd_v_o = 1'b0;
      end
    endcase
  end

endmodule

/* design/inv_sequencer.sv */
/*
 * invalidation sequencer
 * sends one invalidate per sharer except the requester and counts the acks
 */
`include "coh_consts.svh"

module inv_sequencer
  import coh_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  inv_start_t                 inv_start_i,
  input  logic                       inv_start_v_i,
  input  lce_resp_t                  lce_resp_i,
  input  logic                       lce_resp_v_i,
  input  logic                       cmd_grant_i,
  output logic                       inv_cmd_v_o,
  output lce_cmd_t                   inv_cmd_o,
  output logic                       inv_ack_take_o,
  output logic                       inv_busy_o,
  output logic                       dir_w_v_o,
  output logic [`LG_NUM_LCE-1:0]     dir_lce_o,
  output logic [`LG_ASSOC-1:0]       dir_way_o
);

  inv_state_e                          state_r, state_n;
  logic [`NUM_LCE-1:0]                 sharers_r, sharers_n;
  logic [`NUM_LCE-1:0][`LG_ASSOC-1:0]  ways_r;
  logic [`PADDR_WIDTH-1:0]             addr_r;
  logic [`INV_CNT_WIDTH-1:0]           cnt_r, cnt_n;

  logic                                start;
  logic                                send;
  logic [`LG_NUM_LCE-1:0]              pe_id;
  logic [`NUM_LCE-1:0]                 pe_onehot;
  logic [`NUM_LCE-1:0]                 req_onehot;

  assign inv_busy_o = (state_r != e_inv_ready);
  assign start      = inv_start_v_i & ~inv_busy_o;

  // lowest set sharer bit wins
  always_comb begin
    pe_id = '0;
    for (int i = `NUM_LCE - 1; i >= 0; i--) begin
      if (sharers_r[i]) begin
        pe_id = `LG_NUM_LCE'(i);
      end
    end
    pe_onehot        = '0;
    pe_onehot[pe_id] = 1'b1;
    req_onehot       = '0;
    req_onehot[inv_start_i.req_lce] = 1'b1;
  end

  // offer an invalidate whenever sharers remain
  assign inv_cmd_v_o = (state_r == e_inv_cmd) & (|sharers_r);
  assign send        = inv_cmd_v_o & cmd_grant_i;

  always_comb begin
    inv_cmd_o          = '0;
    inv_cmd_o.msg_type = e_cmd_inv;
    inv_cmd_o.dst_id   = pe_id;
    inv_cmd_o.src_id   = `CCE_ID;
    inv_cmd_o.way_id   = ways_r[pe_id];
    inv_cmd_o.addr     = addr_r;
    inv_cmd_o.state    = e_coh_i;
  end

  // directory update tracks each invalidate actually sent
  assign dir_w_v_o = send;
  assign dir_lce_o = pe_id;
  assign dir_way_o = ways_r[pe_id];

  // acks only while a count is outstanding, guards against underflow
  assign inv_ack_take_o = lce_resp_v_i & (lce_resp_i.msg_type == e_resp_inv_ack)
                        & inv_busy_o & (cnt_r != '0);

  always_comb begin
    state_n   = state_r;
    sharers_n = sharers_r;
    cnt_n     = cnt_r;
    if (send) begin
      cnt_n = cnt_n + 1'b1;
    end
    if (inv_ack_take_o) begin
      cnt_n = cnt_n - 1'b1;
    end

    case (state_r)
      e_inv_ready: begin
        if (start) begin
          // requester keeps its copy
          sharers_n = inv_start_i.sharer_hits & ~req_onehot;
          state_n   = e_inv_cmd;
        end
      end

      e_inv_cmd: begin
        if (send) begin
          sharers_n = sharers_r & ~pe_onehot;
        end
        // empty vector with nothing outstanding finishes in one cycle
        if (sharers_n == '0) begin
          state_n = (cnt_n == '0) ? e_inv_ready : e_inv_resp;
        end
      end

      e_inv_resp: begin
        if (cnt_n == '0) begin
          state_n = e_inv_ready;
        end
      end

      default: begin
        state_n = e_inv_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= e_inv_ready;
      sharers_r <= '0;
      cnt_r     <= '0;
    end else begin
      state_r   <= state_n;
      sharers_r <= sharers_n;
      cnt_r     <= cnt_n;
    end
  end

  // request details captured on start
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_r <= inv_start_i.addr;
      ways_r <= inv_start_i.sharer_ways;
    end
  end

endmodule

/* design/msg_arbiter.sv */
/*
 * message arbiter
 * shares the LCE command port and the pending bit write port, makes the dequeues
 */
`include "coh_consts.svh"

module msg_arbiter
  import coh_pkg::*;
(
  input  logic                     mem_resp_v_i,
  input  logic                     fwd_cmd_v_i,
  input  lce_cmd_t                 fwd_cmd_i,
  input  logic                     fwd_clr_v_i,
  input  logic                     fwd_needs_cmd_i,
  input  logic [`PADDR_WIDTH-1:0]  mem_addr_i,
  input  logic                     inv_cmd_v_i,
  input  lce_cmd_t                 inv_cmd_i,
  input  logic                     inv_ack_take_i,
  input  lce_resp_t                lce_resp_i,
  input  logic                     lce_resp_v_i,
  input  lce_req_t                 lce_req_i,
  input  logic                     lce_req_v_i,
  input  logic                     lce_cmd_ready_i,
  output lce_cmd_t                 lce_cmd_o,
  output logic                     lce_cmd_v_o,
  output logic                     cmd_grant_inv_o,
  output logic                     mem_resp_yumi_o,
  output logic                     lce_resp_yumi_o,
  output logic                     lce_req_yumi_o,
  output pend_wr_t                 pend_wr_o
);

  logic                    cmd_fire_fwd;
  logic                    mem_clr;
  logic                    coh_v;
  logic                    coh_clr;
  logic                    req_cached;
  logic [`PADDR_WIDTH-1:0] pend_addr;

  // command port, forwarded memory response ahead of invalidates
  assign lce_cmd_v_o     = fwd_cmd_v_i | inv_cmd_v_i;
  assign lce_cmd_o       = fwd_cmd_v_i ? fwd_cmd_i : inv_cmd_i;
  assign cmd_fire_fwd    = fwd_cmd_v_i & lce_cmd_ready_i;
  assign cmd_grant_inv_o = ~fwd_cmd_v_i & inv_cmd_v_i & lce_cmd_ready_i;

  // responses that send a command complete on fire, the rest right away
  assign mem_resp_yumi_o = mem_resp_v_i & (~fwd_needs_cmd_i | cmd_fire_fwd);

  // pending port, memory clear first
  assign mem_clr = fwd_clr_v_i & (~fwd_needs_cmd_i | cmd_fire_fwd);

  // then a coherence ack
  assign coh_v   = lce_resp_v_i & (lce_resp_i.msg_type == e_resp_coh_ack);
  assign coh_clr = coh_v & ~mem_clr;

  // LCE request last, even uncached ones wait for a free port
  assign lce_req_yumi_o = lce_req_v_i & ~mem_clr & ~coh_clr;
  assign req_cached     = (lce_req_i.msg_type == e_req_rd) | (lce_req_i.msg_type == e_req_wr);

  // inv acks belong to the sequencer, never overlap a coh ack
  assign lce_resp_yumi_o = coh_clr | inv_ack_take_i;

  always_comb begin
    if (mem_clr) begin
      pend_addr = mem_addr_i;
    end else if (coh_clr) begin
      pend_addr = lce_resp_i.addr;
    end else begin
      pend_addr = lce_req_i.addr;
    end
  end

  // way group is just the set index of the winning address
  assign pend_wr_o.w_v       = mem_clr | coh_clr | (lce_req_yumi_o & req_cached);
  assign pend_wr_o.way_group = pend_addr[`LG_BLOCK_BYTES +: `LG_SETS];
  assign pend_wr_o.pending   = lce_req_yumi_o & req_cached;

endmodule

/* design/coh_msg_top.sv */
/*
 * coherence message unit top
 * connects the forwarder, invalidation sequencer and arbiter
 */
`include "coh_consts.svh"

module coh_msg_top
  import coh_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  mem_resp_t               mem_resp_i,
  input  logic                    mem_resp_v_i,
  output logic                    mem_resp_yumi_o,
  input  lce_resp_t               lce_resp_i,
  input  logic                    lce_resp_v_i,
  output logic                    lce_resp_yumi_o,
  input  lce_req_t                lce_req_i,
  input  logic                    lce_req_v_i,
  output logic                    lce_req_yumi_o,
  output lce_cmd_t                lce_cmd_o,
  output logic                    lce_cmd_v_o,
  input  logic                    lce_cmd_ready_i,
  input  inv_start_t              inv_start_i,
  input  logic                    inv_start_v_i,
  output logic                    inv_busy_o,
  output pend_wr_t                pend_wr_o,
  output logic                    dir_w_v_o,
  output logic [`LG_NUM_LCE-1:0]  dir_lce_o,
  output logic [`LG_ASSOC-1:0]    dir_way_o
);

  // forwarder to arbiter
  logic     fwd_cmd_v;
  lce_cmd_t fwd_cmd;
  logic     fwd_clr_v;
  logic     fwd_needs_cmd;

  // sequencer to arbiter and back
  logic     inv_cmd_v;
  lce_cmd_t inv_cmd;
  logic     inv_ack_take;
  logic     cmd_fire_inv;

  mem_resp_forward u_mem_resp_forward (
    .mem_resp_i      (mem_resp_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .fwd_cmd_v_o     (fwd_cmd_v),
    .fwd_cmd_o       (fwd_cmd),
    .fwd_clr_v_o     (fwd_clr_v),
    .fwd_needs_cmd_o (fwd_needs_cmd)
  );

  inv_sequencer u_inv_sequencer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inv_start_i    (inv_start_i),
    .inv_start_v_i  (inv_start_v_i),
    .lce_resp_i     (lce_resp_i),
    .lce_resp_v_i   (lce_resp_v_i),
    .cmd_grant_i    (cmd_fire_inv),
    .inv_cmd_v_o    (inv_cmd_v),
    .inv_cmd_o      (inv_cmd),
    .inv_ack_take_o (inv_ack_take),
    .inv_busy_o     (inv_busy_o),
    .dir_w_v_o      (dir_w_v_o),
    .dir_lce_o      (dir_lce_o),
    .dir_way_o      (dir_way_o)
  );

  msg_arbiter u_msg_arbiter (
    .mem_resp_v_i    (mem_resp_v_i),
    .fwd_cmd_v_i     (fwd_cmd_v),
    .fwd_cmd_i       (fwd_cmd),
    .fwd_clr_v_i     (fwd_clr_v),
    .fwd_needs_cmd_i (fwd_needs_cmd),
    .mem_addr_i      (mem_resp_i.addr),
    .inv_cmd_v_i     (inv_cmd_v),
    .inv_cmd_i       (inv_cmd),
    .inv_ack_take_i  (inv_ack_take),
    .lce_resp_i      (lce_resp_i),
    .lce_resp_v_i    (lce_resp_v_i),
    .lce_req_i       (lce_req_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_cmd_ready_i (lce_cmd_ready_i),
    .lce_cmd_o       (lce_cmd_o),
    .lce_cmd_v_o     (lce_cmd_v_o),
    .cmd_grant_inv_o (cmd_fire_inv),
    .mem_resp_yumi_o (mem_resp_yumi_o),
    .lce_resp_yumi_o (lce_resp_yumi_o),
    .lce_req_yumi_o  (lce_req_yumi_o),
    .pend_wr_o       (pend_wr_o)
  );

endmodule

/* tb/tb_clk_gen.sv */
/*
 * testbench clock and reset source
 * 8 ns clock, reset held high over the first 3 rising edges
 */
module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // synchronous reset, released on an edge
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* tb/coh_msg_assert.sv */
/*
 * coherence message unit protocol checks
 * bound into the top, watches dequeues, directory writes and invalidates
 */
`include "coh_consts.svh"

module coh_msg_assert
  import coh_pkg::*;
(
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    mem_resp_v_i,
  input logic                    mem_resp_yumi_o,
  input logic                    lce_resp_v_i,
  input logic                    lce_resp_yumi_o,
  input logic                    lce_req_v_i,
  input logic                    lce_req_yumi_o,
  input lce_cmd_t                lce_cmd_o,
  input logic                    lce_cmd_v_o,
  input logic                    lce_cmd_ready_i,
  input logic                    inv_busy_o,
  input logic                    dir_w_v_o,
  input logic [`LG_NUM_LCE-1:0]  dir_lce_o,
  input logic [`LG_ASSOC-1:0]    dir_way_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // a dequeue only ever takes valid data
  a_mem_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_yumi_o |-> mem_resp_v_i)
    else $error("memory response dequeued while not valid");

  a_resp_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_resp_yumi_o |-> lce_resp_v_i)
    else $error("LCE response dequeued while not valid");

  a_req_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_yumi_o |-> lce_req_v_i)
    else $error("LCE request dequeued while not valid");

  // directory written only for the invalidate that leaves the port
  a_dir_fire: assert property (@(posedge clk_i) disable iff (reset_i)
    dir_w_v_o |-> (lce_cmd_v_o && lce_cmd_ready_i && lce_cmd_o.msg_type == e_cmd_inv &&
                   lce_cmd_o.dst_id == dir_lce_o && lce_cmd_o.way_id == dir_way_o))
    else $error("directory write does not match the invalidate sent");

  // invalidates belong to a running sequence
  a_inv_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_cmd_v_o && lce_cmd_o.msg_type == e_cmd_inv) |-> inv_busy_o)
    else $error("invalidate offered while the sequencer is idle");

endmodule

bind coh_msg_top coh_msg_assert u_coh_msg_assert (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .mem_resp_v_i    (mem_resp_v_i),
  .mem_resp_yumi_o (mem_resp_yumi_o),
  .lce_resp_v_i    (lce_resp_v_i),
  .lce_resp_yumi_o (lce_resp_yumi_o),
  .lce_req_v_i     (lce_req_v_i),
  .lce_req_yumi_o  (lce_req_yumi_o),
  .lce_cmd_o       (lce_cmd_o),
  .lce_cmd_v_o     (lce_cmd_v_o),
  .lce_cmd_ready_i (lce_cmd_ready_i),
  .inv_busy_o      (inv_busy_o),
  .dir_w_v_o       (dir_w_v_o),
  .dir_lce_o       (dir_lce_o),
  .dir_way_o       (dir_way_o)
);

/* tb/coh_msg_tb.sv */
/*
 * coherence message unit testbench
 * random memory and LCE traffic, invalidation runs, checked against a model
 */
`include "coh_consts.svh"

module coh_msg_tb
  import coh_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TRAFFIC = 600;
  localparam int NUM_INV     = 48;
  localparam int WAIT_LIMIT  = 64;
  localparam int INV_LIMIT   = 200;

  logic                    clk;
  logic                    reset;
  mem_resp_t               mem_resp;
  logic                    mem_resp_v;
  logic                    mem_resp_yumi;
  lce_resp_t               lce_resp;
  logic                    lce_resp_v;
  logic                    lce_resp_yumi;
  lce_req_t                lce_req;
  logic                    lce_req_v;
  logic                    lce_req_yumi;
  lce_cmd_t                lce_cmd;
  logic                    lce_cmd_v;
  logic                    lce_cmd_ready;
  inv_start_t              inv_start;
  logic                    inv_start_v;
  logic                    inv_busy;
  pend_wr_t                pend_wr;
  logic                    dir_w_v;
  logic [`LG_NUM_LCE-1:0]  dir_lce;
  logic [`LG_ASSOC-1:0]    dir_way;
  integer                  seed;

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  coh_msg_top u_coh_msg_top (
    .clk_i           (clk),
    .reset_i         (reset),
    .mem_resp_i      (mem_resp),
    .mem_resp_v_i    (mem_resp_v),
    .mem_resp_yumi_o (mem_resp_yumi),
    .lce_resp_i      (lce_resp),
    .lce_resp_v_i    (lce_resp_v),
    .lce_resp_yumi_o (lce_resp_yumi),
    .lce_req_i       (lce_req),
    .lce_req_v_i     (lce_req_v),
    .lce_req_yumi_o  (lce_req_yumi),
    .lce_cmd_o       (lce_cmd),
    .lce_cmd_v_o     (lce_cmd_v),
    .lce_cmd_ready_i (lce_cmd_ready),
    .inv_start_i     (inv_start),
    .inv_start_v_i   (inv_start_v),
    .inv_busy_o      (inv_busy),
    .pend_wr_o       (pend_wr),
    .dir_w_v_o       (dir_w_v),
    .dir_lce_o       (dir_lce),
    .dir_way_o       (dir_way)
  );

  task automatic check(input string name, input logic [255:0] expected,
                       input logic [255:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // way group of an address is its set index
  function automatic logic [`LG_SETS-1:0] set_index(input logic [`PADDR_WIDTH-1:0] a);
    return a[`LG_BLOCK_BYTES +: `LG_SETS];
  endfunction

  function automatic mem_resp_t random_mem_resp();
    mem_resp_t r;
    r.msg_type = mem_msg_type_e'(3'(pick(5)));
    r.addr     = `PADDR_WIDTH'($random(seed));
    r.data     = {$random(seed), $random(seed), $random(seed), $random(seed)};
    r.lce_id   = `LG_NUM_LCE'(pick(`NUM_LCE));
    r.way_id   = `LG_ASSOC'(pick(`LCE_ASSOC));
    r.state    = coh_state_e'(2'(pick(4)));
    return r;
  endfunction

  // command an LCE should see for a given memory response
  function automatic lce_cmd_t expected_fwd_cmd(input mem_resp_t r);
    lce_cmd_t c;
    c        = '0;
    c.dst_id = r.lce_id;
    c.src_id = `CCE_ID;
    c.addr   = r.addr;
    c.state  = e_coh_i;
    if (r.msg_type == e_mem_rd || r.msg_type == e_mem_wr) begin
      c.msg_type = e_cmd_data;
      c.way_id   = r.way_id;
      c.state    = r.state;
      c.data     = r.data;
    end else if (r.msg_type == e_mem_uc_rd) begin
      c.msg_type                  = e_cmd_uc_data;
      c.data[`DWORD_WIDTH-1:0]    = r.data[`DWORD_WIDTH-1:0];
    end else begin
      c.msg_type = e_cmd_uc_st_done;
    end
    return c;
  endfunction

  // memory responses, coherence acks and LCE requests all at once
  task automatic run_traffic();
    int       cyc;
    int       mem_wait;
    int       resp_wait;
    int       req_wait;
    logic     mem_taken;
    logic     resp_taken;
    logic     req_taken;
    logic     cmd_v;
    logic     fire;
    logic     mem_clr;
    logic     coh_clr;
    logic     req_take;
    pend_wr_t pend;
    cyc        = 0;
    mem_wait   = 0;
    resp_wait  = 0;
    req_wait   = 0;
    mem_taken  = 1'b0;
    resp_taken = 1'b0;
    req_taken  = 1'b0;
    while (cyc < NUM_TRAFFIC || mem_resp_v || lce_resp_v || lce_req_v) begin
      @(posedge clk);
      lce_cmd_ready <= (pick(3) != 0);
      // a channel gets new data only once the old one was taken
      if (!mem_resp_v || mem_taken) begin
        mem_wait = 0;
        mem_resp_v <= (cyc < NUM_TRAFFIC) && (pick(4) != 0);
        mem_resp   <= random_mem_resp();
      end
      if (!lce_resp_v || resp_taken) begin
        resp_wait = 0;
        lce_resp_v <= (cyc < NUM_TRAFFIC) && (pick(2) != 0);
        lce_resp   <= '{msg_type: e_resp_coh_ack, src_id: `LG_NUM_LCE'(pick(`NUM_LCE)),
                        addr: `PADDR_WIDTH'($random(seed))};
      end
      if (!lce_req_v || req_taken) begin
        req_wait = 0;
        lce_req_v <= (cyc < NUM_TRAFFIC) && (pick(2) != 0);
        lce_req   <= '{msg_type: lce_req_type_e'(2'(pick(4))),
                       src_id: `LG_NUM_LCE'(pick(`NUM_LCE)), addr: `PADDR_WIDTH'($random(seed))};
      end

      @(negedge clk);
      cmd_v    = mem_resp_v && (mem_resp.msg_type != e_mem_wb);
      fire     = cmd_v && lce_cmd_ready;
      mem_clr  = mem_resp_v && ((mem_resp.msg_type == e_mem_wb) ||
                 (fire && (mem_resp.msg_type == e_mem_rd || mem_resp.msg_type == e_mem_wr)));
      coh_clr  = lce_resp_v && !mem_clr;
      req_take = lce_req_v && !mem_clr && !coh_clr;
      pend     = '0;
      if (mem_clr) begin
        pend = '{w_v: 1'b1, way_group: set_index(mem_resp.addr), pending: 1'b0};
      end else if (coh_clr) begin
        pend = '{w_v: 1'b1, way_group: set_index(lce_resp.addr), pending: 1'b0};
      end else if (req_take && (lce_req.msg_type == e_req_rd || lce_req.msg_type == e_req_wr)) begin
        pend = '{w_v: 1'b1, way_group: set_index(lce_req.addr), pending: 1'b1};
      end

      check("traffic cmd valid", cmd_v, lce_cmd_v);
      if (cmd_v) begin
        check("traffic cmd", expected_fwd_cmd(mem_resp), lce_cmd);
      end
      check("mem resp yumi", mem_resp_v && (mem_resp.msg_type == e_mem_wb || fire),
            mem_resp_yumi);
      check("coh ack yumi", coh_clr, lce_resp_yumi);
      check("lce req yumi", req_take, lce_req_yumi);
      check("pending write valid", pend.w_v, pend_wr.w_v);
      if (pend.w_v) begin
        check("pending write", pend, pend_wr);
      end
      check("traffic dir write", 1'b0, dir_w_v);
      check("traffic busy", 1'b0, inv_busy);

      mem_taken  = mem_resp_yumi;
      resp_taken = lce_resp_yumi;
      req_taken  = lce_req_yumi;
      // each channel has its own dequeue timeout
      if (mem_resp_v && !mem_taken) begin
        mem_wait++;
        if (mem_wait > WAIT_LIMIT) begin
          abort_run("memory response was never dequeued");
        end
      end
      if (lce_resp_v && !resp_taken) begin
        resp_wait++;
        if (resp_wait > WAIT_LIMIT) begin
          abort_run("coherence ack was never dequeued");
        end
      end
      if (lce_req_v && !req_taken) begin
        req_wait++;
        if (req_wait > WAIT_LIMIT) begin
          abort_run("LCE request was never dequeued");
        end
      end
      cyc++;
    end
  endtask

  task automatic run_invalidations();
    inv_start_t             st;
    logic [`LG_NUM_LCE-1:0] exp_dst[$];
    logic [`LG_NUM_LCE-1:0] ack_lce[$];
    int                     ack_due[$];
    logic [`LG_NUM_LCE-1:0] id;
    lce_cmd_t               inv;
    int                     n;
    int                     outstanding;
    int                     busy_cycles;
    logic                   empty_start;
    logic                   finished;
    logic                   all_done;
    logic                   ack_taken;
    logic                   sent;
    for (int t = 0; t < NUM_INV; t++) begin
      st.addr        = `PADDR_WIDTH'($random(seed));
      st.req_lce     = `LG_NUM_LCE'(pick(`NUM_LCE));
      st.sharer_hits = `NUM_LCE'(pick(256));
      st.sharer_ways = 16'($random(seed));
      // now and then only the requester shares the block
      if (t % 8 == 0) begin
        st.sharer_hits = `NUM_LCE'(1) << st.req_lce;
      end
      exp_dst.delete();
      for (int i = 0; i < `NUM_LCE; i++) begin
        if (st.sharer_hits[i] && i != st.req_lce) begin
          exp_dst.push_back(`LG_NUM_LCE'(i));
        end
      end
      empty_start = (exp_dst.size() == 0);

      @(posedge clk);
      inv_start   <= st;
      inv_start_v <= 1'b1;
      @(negedge clk);
      check("busy before start", 1'b0, inv_busy);
      @(posedge clk);
      inv_start_v <= 1'b0;

      n           = 0;
      outstanding = 0;
      busy_cycles = 0;
      finished    = 1'b0;
      all_done    = 1'b0;
      ack_taken   = 1'b0;
      while (!finished) begin
        @(negedge clk);
        n++;
        if (n > INV_LIMIT) begin
          abort_run("invalidation sequence did not finish in time");
        end
        if (!inv_busy) begin
          if (exp_dst.size() != 0 || outstanding != 0) begin
            abort_run("inv_busy_o fell with invalidates or acks still open");
          end
          finished = 1'b1;
        end else begin
          if (all_done) begin
            abort_run("inv_busy_o stayed high after the last ack");
          end
          busy_cycles++;
          check("inv cmd valid", exp_dst.size() != 0, lce_cmd_v);
          sent = (exp_dst.size() != 0) && lce_cmd_ready;
          check("dir write valid", sent, dir_w_v);
          if (exp_dst.size() != 0) begin
            inv          = '0;
            inv.msg_type = e_cmd_inv;
            inv.dst_id   = exp_dst[0];
            inv.src_id   = `CCE_ID;
            inv.way_id   = st.sharer_ways[exp_dst[0]];
            inv.addr     = st.addr;
            inv.state    = e_coh_i;
            check("inv cmd", inv, lce_cmd);
          end
          if (sent) begin
            check("dir lce", exp_dst[0], dir_lce);
            check("dir way", st.sharer_ways[exp_dst[0]], dir_way);
            ack_lce.push_back(exp_dst.pop_front());
            ack_due.push_back(n + 1 + int'(pick(6)));
            outstanding++;
          end
          check("inv ack yumi", lce_resp_v, lce_resp_yumi);
          ack_taken = lce_resp_yumi;
          if (ack_taken) begin
            outstanding--;
          end
          check("inv phase mem yumi", 1'b0, mem_resp_yumi);
          check("inv phase req yumi", 1'b0, lce_req_yumi);
          check("inv phase pending write", 1'b0, pend_wr.w_v);
          all_done = (exp_dst.size() == 0) && (outstanding == 0);
        end

        if (!finished) begin
          @(posedge clk);
          lce_cmd_ready <= (pick(3) != 0);
          // LCE model answers each invalidate after its delay
          if (ack_taken || !lce_resp_v) begin
            if (ack_due.size() != 0 && ack_due[0] <= n) begin
              id = ack_lce.pop_front();
              void'(ack_due.pop_front());
              lce_resp   <= '{msg_type: e_resp_inv_ack, src_id: id, addr: st.addr};
              lce_resp_v <= 1'b1;
            end else begin
              lce_resp_v <= 1'b0;
            end
          end
        end
      end

      if (empty_start) begin
        check("busy cycles for empty sharers", 1, busy_cycles);
      end else if (busy_cycles == 0) begin
        abort_run("inv_busy_o never rose for a non-empty sharer vector");
      end
    end
  endtask

  initial begin
    int n;
    seed          = 32'h0c8ce537;
    mem_resp      = '0;
    mem_resp_v    = 1'b0;
    lce_resp      = '0;
    lce_resp_v    = 1'b0;
    lce_req       = '0;
    lce_req_v     = 1'b0;
    lce_cmd_ready = 1'b0;
    inv_start     = '0;
    inv_start_v   = 1'b0;

    n = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      n++;
      if (n > 10) begin
        abort_run("reset was never released");
      end
    end
    @(negedge clk);
    check("reset cmd valid", 1'b0, lce_cmd_v);
    check("reset mem yumi", 1'b0, mem_resp_yumi);
    check("reset resp yumi", 1'b0, lce_resp_yumi);
    check("reset req yumi", 1'b0, lce_req_yumi);
    check("reset pending write", 1'b0, pend_wr.w_v);
    check("reset dir write", 1'b0, dir_w_v);
    check("reset busy", 1'b0, inv_busy);

    run_traffic();
    run_invalidations();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
design/coh_pkg.sv
design/mem_resp_forward.sv
design/inv_sequencer.sv
design/msg_arbiter.sv
design/coh_msg_top.sv
tb/tb_clk_gen.sv
tb/coh_msg_assert.sv
tb/coh_msg_tb.sv

/* Makefile */
# Verilator build and run for the coherence message unit testbench
# any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= coh_msg_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
